/* verilog.f */
hw/rv_pkg.sv
hw/rv_seq.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
test/rv_core_props.sv
test/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_core -f verilog.f \
    --Mdir "$BUILD_DIR" -o Vtb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# raise the error limit so assertion failures reach the closing summary
"./$BUILD_DIR/Vtb_rv_core" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] RESET_PC     = 32'h40;
    localparam logic [31:0] HALT_WORD    = 32'h0000006f; // jal x0, 0
    localparam int          CPI_WORST    = 6;            // fetch 2, exec 1, mem 2, wb 1
    localparam int          STALL_MARGIN = 6;
    localparam int          OPC_IMM      = 'h13;
    localparam int          OPC_LOAD     = 'h03;
    localparam int          OPC_JALR     = 'h67;

    logic        clk;
    logic        rst       = 1'b1;
    logic        mem_ready = 1'b0;
    logic [31:0] mem_rdata = '0;
    wire         mem_valid;
    wire         mem_we;
    wire  [31:0] mem_addr;
    wire  [31:0] mem_wdata;

    logic [31:0] image   [1024]; // program and data image copied into mem during reset
    logic [31:0] mem     [1024];
    logic [31:0] ref_mem [1024];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] halt_pc;
    string       test_name    = "reset";
    int          errors       = 0;
    int          n_instr      = 0;
    int          store_idx    = 0;
    int          prog_idx     = 0;
    int          store_off    = 0;
    bit          random_ready = 1'b0;
    bit          first_seen   = 1'b0;
    bit          halted       = 1'b0;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk(clk), .rst(rst),
        .mem_valid_o(mem_valid), .mem_we_o(mem_we),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rtype(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] utype(input int imm, input int rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] word);
        image[prog_idx] = word;
        prog_idx++;
    endtask

    // sw rs to the next free word of the result area at x20
    task automatic store_reg(input int rs);
        emit(stype(store_off, rs, 20));
        store_off += 4;
    endtask

    task automatic build_image();
        for (int k = 0; k < 1024; k++) begin
            image[k] = (32'h9e3779b9 * k) ^ (k << 20); // odd multiplier gives unique words
        end
        prog_idx  = int'(RESET_PC) / 4;
        store_off = 0;
        emit(itype(-7, 0, 0, 1, OPC_IMM));
        emit(itype(12, 0, 0, 2, OPC_IMM));
        emit(utype('hABCDE, 3));
        emit(itype('h400, 0, 0, 20, OPC_IMM)); // result area
        emit(itype('h600, 0, 0, 21, OPC_IMM)); // preloaded data
        store_reg(3);
        emit(rtype(0, 2, 1, 0, 4));  // add
        store_reg(4);
        emit(rtype(32, 2, 1, 0, 5)); // sub
        store_reg(5);
        emit(rtype(0, 1, 3, 4, 6));  // xor
        store_reg(6);
        emit(rtype(0, 2, 3, 6, 7));  // or
        store_reg(7);
        emit(rtype(0, 1, 3, 7, 8));  // and
        store_reg(8);
        emit(rtype(0, 2, 1, 1, 9));  // sll
        store_reg(9);
        emit(rtype(0, 2, 1, 5, 10)); // srl
        store_reg(10);
        emit(itype('h555, 1, 4, 11, OPC_IMM));
        store_reg(11);
        emit(itype(-256, 2, 6, 12, OPC_IMM));
        store_reg(12);
        emit(itype('h3c, 1, 7, 13, OPC_IMM));
        store_reg(13);
        emit(itype(27, 2, 1, 14, OPC_IMM));
        store_reg(14);
        emit(itype(3, 1, 5, 15, OPC_IMM));
        store_reg(15);
        emit(itype(0, 21, 2, 16, OPC_LOAD));
        store_reg(16);
        emit(itype(8, 21, 2, 17, OPC_LOAD));
        store_reg(17);
        emit(itype(4, 21, 2, 0, OPC_LOAD));
        store_reg(0);
        emit(itype(-4, 21, 2, 18, OPC_LOAD));
        store_reg(18);
        // backward loop whose store runs three times
        emit(itype(3, 0, 0, 25, OPC_IMM));
        emit(itype(-1, 25, 0, 25, OPC_IMM));
        store_reg(25);
        emit(btype(-8, 0, 25, 1));
        // each taken branch skips the store behind it
        emit(btype(8, 1, 1, 0));
        store_reg(1);
        emit(btype(8, 2, 1, 0));
        store_reg(1);
        emit(btype(8, 2, 1, 1));
        store_reg(1);
        emit(btype(8, 1, 1, 1));
        store_reg(1);
        emit(btype(8, 2, 1, 4));
        store_reg(1);
        emit(btype(8, 1, 2, 4));
        store_reg(1);
        emit(btype(8, 5, 1, 4));
        store_reg(1);
        emit(btype(8, 1, 2, 5));
        store_reg(1);
        emit(btype(8, 2, 1, 5));
        store_reg(1);
        emit(btype(8, 1, 1, 5));
        store_reg(1);
        emit(jtype(8, 22));
        store_reg(1);
        store_reg(22);
        emit(itype(17, 22, 0, 24, OPC_JALR)); // lands on bit 0 cleared
        store_reg(1);
        store_reg(24);
        emit(jtype(0, 0));
    endtask

    function automatic logic [31:0] rv32_alu(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // instruction-level model that fills the expected store queues
    function automatic int run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] immi;
        logic [31:0] imms;
        logic [31:0] immb;
        logic [31:0] immj;
        logic [31:0] addr;
        logic [31:0] wval;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        bit          wen;
        bit          taken;
        int          count;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        for (int k = 0; k < 1024; k++) begin
            ref_mem[k] = image[k];
        end
        exp_addr.delete();
        exp_data.delete();
        pc      = RESET_PC;
        halt_pc = '1;
        count   = 0;
        while (count < 4096) begin
            ins = ref_mem[pc[11:2]];
            count++;
            if (ins == HALT_WORD) begin
                halt_pc = pc;
                break;
            end
            rd      = ins[11:7];
            f3      = ins[14:12];
            rs1     = ins[19:15];
            rs2     = ins[24:20];
            immi    = {{20{ins[31]}}, ins[31:20]};
            imms    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immb    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immj    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 4;
            wen     = 1'b1;
            wval    = '0;
            case (ins[6:0])
                7'h33: wval = rv32_alu(f3, ins[30], x[rs1], x[rs2]);
                7'h13: wval = rv32_alu(f3, 1'b0, x[rs1], immi);
                7'h37: wval = {ins[31:12], 12'h000};
                7'h03: begin
                    addr = x[rs1] + immi;
                    wval = ref_mem[addr[11:2]];
                end
                7'h23: begin
                    addr = x[rs1] + imms;
                    exp_addr.push_back(addr);
                    exp_data.push_back(x[rs2]);
                    ref_mem[addr[11:2]] = x[rs2];
                    wen = 1'b0;
                end
                7'h63: begin
                    case (f3)
                        3'b000:  taken = (x[rs1] == x[rs2]);
                        3'b001:  taken = (x[rs1] != x[rs2]);
                        3'b100:  taken = ($signed(x[rs1]) < $signed(x[rs2]));
                        default: taken = ($signed(x[rs1]) >= $signed(x[rs2]));
                    endcase
                    if (taken) begin
                        next_pc = pc + immb;
                    end
                    wen = 1'b0;
                end
                7'h6f: begin
                    wval    = pc + 4;
                    next_pc = pc + immj;
                end
                7'h67: begin
                    wval    = pc + 4;
                    next_pc = (x[rs1] + immi) & 32'hffff_fffe;
                end
                default: wen = 1'b0;
            endcase
            if (wen && rd != 5'd0) begin
                x[rd] = wval;
            end
            pc = next_pc;
        end
        return count;
    endfunction

    // memory model raises ready one cycle after it sees a request
    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            for (int k = 0; k < 1024; k++) begin
                mem[k] <= image[k];
            end
        end else if (mem_valid && mem_ready) begin
            mem_ready <= 1'b0;
            if (mem_we) begin
                mem[mem_addr[11:2]] <= mem_wdata;
            end
        end else if (mem_valid) begin
            mem_ready <= random_ready ? (($urandom % 2) == 0) : 1'b1;
            mem_rdata <= mem[mem_addr[11:2]];
        end
    end

    // compare completed bus transfers with the reference
    always @(posedge clk) begin
        if (rst) begin
            first_seen = 1'b0;
            halted     = 1'b0;
            store_idx  = 0;
            if (mem_valid) begin
                errors++;
                $display("ERROR %s: bus request raised while reset is high", test_name);
            end
        end else if (mem_valid && mem_ready) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                if (mem_we || mem_addr !== RESET_PC) begin
                    errors++;
                    $display("ERROR %s first fetch: expected read at %h, actual %s at %h",
                             test_name, RESET_PC, mem_we ? "write" : "read", mem_addr);
                end
            end
            if (mem_we) begin
                if (store_idx >= exp_addr.size()) begin
                    errors++;
                    $display("ERROR %s: store %0d to %h goes past the expected count",
                             test_name, store_idx, mem_addr);
                end else begin
                    if (mem_addr !== exp_addr[store_idx]) begin
                        errors++;
                        $display("ERROR %s store %0d addr: expected %h, actual %h",
                                 test_name, store_idx, exp_addr[store_idx], mem_addr);
                    end
                    if (mem_wdata !== exp_data[store_idx]) begin
                        errors++;
                        $display("ERROR %s store %0d data: expected %h, actual %h",
                                 test_name, store_idx, exp_data[store_idx], mem_wdata);
                    end
                end
                store_idx++;
            end else if (mem_addr == halt_pc) begin
                halted = 1'b1;
            end
        end
    end

    task automatic run_program(input string name, input bit stalls);
        @(posedge clk);
        test_name    <= name;
        random_ready <= stalls;
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait (halted);
        @(posedge clk);
        if (store_idx != exp_addr.size()) begin
            errors++;
            $display("ERROR %s store count: expected %0d, actual %0d",
                     test_name, exp_addr.size(), store_idx);
        end
    endtask

    initial begin
        void'($urandom(32'hbdaebf5b));
        build_image();
        n_instr = run_model();
        run_program("no stalls", 1'b0);
        run_program("random stalls", 1'b1);
        $display("errors: %0d in checks, %0d in bus assertions",
                 errors, UUT.props.fail_count);
        if (errors == 0 && UUT.props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the reference instruction count over both passes
    initial begin
        int limit;
        wait (n_instr > 0);
        limit = 2 * (n_instr * CPI_WORST * STALL_MARGIN + 16);
        repeat (limit) @(posedge clk);
        $display("timeout: the core did not reach its halt loop within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/rv_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_props import rv_pkg::*; (
    input wire            clk,
    input wire            rst,
    input wire            mem_valid_o,
    input wire            mem_we_o,
    input wire [XLEN-1:0] mem_addr_o,
    input wire [XLEN-1:0] mem_wdata_o,
    input wire            mem_ready_i
);

    int fail_count = 0; // read by the testbench at the end

    no_valid_in_reset: assert property (@(posedge clk) rst |-> !mem_valid_o)
        else begin
            fail_count++;
            $error("bus request raised during reset");
        end

    // request held unchanged until ready
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else begin
            fail_count++;
            $error("bus request changed while stalled");
        end

    we_only_with_valid: assert property (@(posedge clk) disable iff (rst)
        mem_we_o |-> mem_valid_o)
        else begin
            fail_count++;
            $error("write enable without a valid request");
        end

endmodule

bind rv_core rv_core_props props (
    .clk(clk), .rst(rst),
    .mem_valid_o(mem_valid_o), .mem_we_o(mem_we_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
    .mem_ready_i(mem_ready_i)
);

`default_nettype wire

/* hw/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rst,
    output logic            mem_valid_o,
    output logic            mem_we_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    input  wire             mem_ready_i,
    input  wire  [XLEN-1:0] mem_rdata_i
);

    instr_u            instr;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   load_data;
    logic              wb_stage;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
    alu_op_e           alu_op;
    logic              use_imm;
    wb_sel_e           wb_sel;
    logic              is_mem;
    logic              is_store;
    logic              is_branch;
    logic              is_jal;
    logic              is_jalr;
    logic [2:0]        funct3;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   ex_addr;
    logic              branch_taken;
    logic [XLEN-1:0]   jump_target;
    logic              rf_we;
    logic [XLEN-1:0]   rf_wdata;
    logic [XLEN-1:0]   next_pc;

    rv_seq #(
        .RESET_PC(RESET_PC)
    ) u_seq (
        .clk(clk), .rst(rst),
        .mem_ready_i(mem_ready_i), .mem_rdata_i(mem_rdata_i),
        .is_mem_i(is_mem), .is_store_i(is_store),
        .mem_addr_i(ex_addr), .store_data_i(rs2_data), .next_pc_i(next_pc),
        .mem_valid_o(mem_valid_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .instr_o(instr), .pc_o(pc), .load_data_o(load_data), .wb_stage_o(wb_stage)
    );

    rv_decode u_decode (
        .instr_i(instr),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .alu_op_o(alu_op), .use_imm_o(use_imm), .wb_sel_o(wb_sel),
        .is_mem_o(is_mem), .is_store_o(is_store), .is_branch_o(is_branch),
        .is_jal_o(is_jal), .is_jalr_o(is_jalr), .funct3_o(funct3)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .we_i(rf_we), .wdata_i(rf_wdata),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    rv_execute u_execute (
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm), .pc_i(pc),
        .alu_op_i(alu_op), .use_imm_i(use_imm), .is_branch_i(is_branch),
        .is_jalr_i(is_jalr), .funct3_i(funct3),
        .alu_result_o(alu_result), .mem_addr_o(ex_addr),
        .branch_taken_o(branch_taken), .jump_target_o(jump_target)
    );

    rv_result u_result (
        .wb_sel_i(wb_sel), .wb_stage_i(wb_stage), .rd_i(rd),
        .alu_result_i(alu_result), .load_data_i(load_data), .pc_i(pc),
        .branch_taken_i(branch_taken), .is_jal_i(is_jal), .is_jalr_i(is_jalr),
        .jump_target_i(jump_target),
        .rf_we_o(rf_we), .rf_wdata_o(rf_wdata), .next_pc_o(next_pc)
    );

endmodule

`default_nettype wire

/* hw/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_result import rv_pkg::*; (
    input  wire  wb_sel_e     wb_sel_i,
    input  wire               wb_stage_i,
    input  wire  [REG_AW-1:0] rd_i,
    input  wire  [XLEN-1:0]   alu_result_i,
    input  wire  [XLEN-1:0]   load_data_i,
    input  wire  [XLEN-1:0]   pc_i,
    input  wire               branch_taken_i,
    input  wire               is_jal_i,
    input  wire               is_jalr_i,
    input  wire  [XLEN-1:0]   jump_target_i,
    output logic              rf_we_o,
    output logic [XLEN-1:0]   rf_wdata_o,
    output logic [XLEN-1:0]   next_pc_o
);

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  rf_wdata_o = load_data_i;
            WB_PC4:  rf_wdata_o = pc_plus4;
            default: rf_wdata_o = alu_result_i;
        endcase
    end

    // single write per instruction, in the WB cycle only
    assign rf_we_o = wb_stage_i & (wb_sel_i != WB_NONE) & (rd_i != '0);

    assign next_pc_o = (branch_taken_i | is_jal_i | is_jalr_i) ? jump_target_i : pc_plus4;

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  wire  [XLEN-1:0] rs1_data_i,
    input  wire  [XLEN-1:0] rs2_data_i,
    input  wire  [XLEN-1:0] imm_i,
    input  wire  [XLEN-1:0] pc_i,
    input  wire  alu_op_e   alu_op_i,
    input  wire             use_imm_i,
    input  wire             is_branch_i,
    input  wire             is_jalr_i,
    input  wire  [2:0]      funct3_i,
    output logic [XLEN-1:0] alu_result_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] jump_target_o
);

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] addr_sum;
    logic            rs_equal;
    logic            rs_less;

    assign operand_b = use_imm_i ? imm_i : rs2_data_i;
    assign addr_sum  = rs1_data_i + imm_i; // load/store address and jalr target
    assign rs_equal  = (rs1_data_i == rs2_data_i);
    assign rs_less   = ($signed(rs1_data_i) < $signed(rs2_data_i));

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_result_o = rs1_data_i - operand_b;
            ALU_XOR:    alu_result_o = rs1_data_i ^ operand_b;
            ALU_OR:     alu_result_o = rs1_data_i | operand_b;
            ALU_AND:    alu_result_o = rs1_data_i & operand_b;
            ALU_SLL:    alu_result_o = rs1_data_i << operand_b[4:0];
            ALU_SRL:    alu_result_o = rs1_data_i >> operand_b[4:0];
            ALU_PASS_B: alu_result_o = operand_b;
            default:    alu_result_o = rs1_data_i + operand_b;
        endcase
    end

    always_comb begin
        branch_taken_o = 1'b0;
        if (is_branch_i) begin
            case (funct3_i)
                3'b000:  branch_taken_o = rs_equal;  // beq
                3'b001:  branch_taken_o = !rs_equal; // bne
                3'b100:  branch_taken_o = rs_less;   // blt
                3'b101:  branch_taken_o = !rs_less;  // bge
                default: branch_taken_o = 1'b0;
            endcase
        end
    end

    assign mem_addr_o    = addr_sum;
    assign jump_target_o = is_jalr_i ? {addr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [REG_AW-1:0] rs1_i,
    input  wire  [REG_AW-1:0] rs2_i,
    input  wire  [REG_AW-1:0] rd_i,
    input  wire               we_i,
    input  wire  [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 2**REG_AW; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // x0 never written, stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  wire instr_u       instr_i,
    output logic [REG_AW-1:0] rs1_o,
    output logic [REG_AW-1:0] rs2_o,
    output logic [REG_AW-1:0] rd_o,
    output logic [XLEN-1:0]   imm_o,
    output alu_op_e           alu_op_o,
    output logic              use_imm_o,
    output wb_sel_e           wb_sel_o,
    output logic              is_mem_o,
    output logic              is_store_o,
    output logic              is_branch_o,
    output logic              is_jal_o,
    output logic              is_jalr_o,
    output logic [2:0]        funct3_o
);

    // alt selects SUB, only meaningful for register ops
    function automatic alu_op_e alu_op_from(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD; // slt/sltu not supported
        endcase
    endfunction

    always_comb begin
        rs1_o       = instr_i.r.rs1;
        rs2_o       = instr_i.r.rs2;
        funct3_o    = instr_i.r.funct3;
        rd_o        = '0;
        imm_o       = '0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        wb_sel_o    = WB_NONE;
        is_mem_o    = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        case (instr_i.r.opcode)
            OP_REG: begin
                rd_o     = instr_i.r.rd;
                alu_op_o = alu_op_from(instr_i.r.funct3, instr_i.r.funct7[5]);
                wb_sel_o = WB_ALU;
            end
            OP_IMM: begin
                rd_o      = instr_i.i.rd;
                imm_o     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                alu_op_o  = alu_op_from(instr_i.i.funct3, 1'b0); // no subi
                use_imm_o = 1'b1;
                wb_sel_o  = WB_ALU;
            end
            OP_LOAD: begin
                rd_o     = instr_i.i.rd;
                imm_o    = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                wb_sel_o = WB_MEM;
                is_mem_o = 1'b1;
            end
            OP_STORE: begin
                imm_o      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
                is_mem_o   = 1'b1;
                is_store_o = 1'b1;
            end
            OP_BRANCH: begin
                imm_o       = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                               instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                is_branch_o = 1'b1;
            end
            OP_JAL: begin
                rd_o     = instr_i.j.rd;
                imm_o    = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                            instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
                wb_sel_o = WB_PC4;
                is_jal_o = 1'b1;
            end
            OP_JALR: begin
                rd_o      = instr_i.i.rd;
                imm_o     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                wb_sel_o  = WB_PC4;
                is_jalr_o = 1'b1;
            end
            OP_LUI: begin
                rd_o      = instr_i.u.rd;
                imm_o     = {instr_i.u.imm31_12, 12'b0};
                alu_op_o  = ALU_PASS_B;
                use_imm_o = 1'b1;
                wb_sel_o  = WB_ALU;
            end
            default: ; // unknown opcode falls through as a nop
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_seq import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             mem_ready_i,
    input  wire  [XLEN-1:0] mem_rdata_i,
    input  wire             is_mem_i,
    input  wire             is_store_i,
    input  wire  [XLEN-1:0] mem_addr_i,
    input  wire  [XLEN-1:0] store_data_i,
    input  wire  [XLEN-1:0] next_pc_i,
    output logic            mem_valid_o,
    output logic            mem_we_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    output instr_u          instr_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] load_data_o,
    output logic            wb_stage_o
);

    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;
    localparam logic [1:0] S_WB    = 2'd3;

    logic [1:0]      state;
    logic [XLEN-1:0] pc;
    instr_u          instr_q;
    logic [XLEN-1:0] load_q;
    logic            bus_done;

    assign bus_done = mem_valid_o & mem_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_FETCH;
            pc          <= RESET_PC;
            mem_valid_o <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (bus_done) begin
                        state       <= S_EXEC;
                        mem_valid_o <= 1'b0;
                    end else begin
                        mem_valid_o <= 1'b1; // only low here right after reset
                    end
                end
                S_EXEC: begin
                    state       <= is_mem_i ? S_MEM : S_WB;
                    mem_valid_o <= is_mem_i;
                end
                S_MEM: begin
                    if (bus_done) begin
                        state       <= S_WB;
                        mem_valid_o <= 1'b0;
                    end
                end
                S_WB: begin
                    state       <= S_FETCH;
                    pc          <= next_pc_i;
                    mem_valid_o <= 1'b1; // next fetch starts right away
                end
            endcase
        end
    end

    // instruction and load data captured on the completing edge
    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus_done) begin
            instr_q <= mem_rdata_i;
        end
        if (state == S_MEM && bus_done) begin
            load_q <= mem_rdata_i;
        end
    end

    // address and data come from regs and ir, stable until WB
    assign mem_we_o    = (state == S_MEM) & is_store_i;
    assign mem_addr_o  = (state == S_MEM) ? mem_addr_i : pc;
    assign mem_wdata_o = store_data_i;

    assign instr_o     = instr_q;
    assign pc_o        = pc;
    assign load_data_o = load_q;
    assign wb_stage_o  = (state == S_WB);

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // base opcodes, instr[6:0]
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC4 // link value for jal/jalr
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // scrambled branch offset, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
        u_fmt_t u;
    } instr_u;

endpackage

`default_nettype wire
